//--- err_lock_settings.svh
`ifndef ERR_LOCK_SETTINGS_SVH
`define ERR_LOCK_SETTINGS_SVH

// Source counts of the aggregation path
`define ERR_OVF_CH   8                            // FIFO overflow interrupts
`define ERR_ALIGN_CH 4                            // Data type alignment fail interrupts
`define ERR_SRC_N    (`ERR_OVF_CH + `ERR_ALIGN_CH) // Overflow first, then align fail

// Event counter
`define ERR_CNT_W    4                            // Saturates at 15

`endif

//--- err_lock_pkg.sv
`default_nettype none

`include "err_lock_settings.svh"

package err_lock_pkg;

   typedef logic [`ERR_SRC_N-1:0]         src_vec_t; // One bit per source
   typedef logic [$clog2(`ERR_SRC_N)-1:0] src_sel_t; // Source index

   // Host command opcodes
   typedef enum logic [1:0] {
      OP_SET_MASK  = 2'd0,                           // Load mask from wdata
      OP_CLEAR     = 2'd1,                           // Zero one counter
      OP_READ_CNT  = 2'd2,                           // Counter of sel into rdata
      OP_READ_LOCK = 2'd3                            // Lock vector into rdata
   } cmd_op_e;

   typedef enum logic [1:0] {
      CMD_IDLE = 2'd0,                               // Wait for req
      CMD_EXEC = 2'd1,                               // Exec strobe out
      CMD_ACK  = 2'd2,                               // Ack high, wait for req low
      CMD_DONE = 2'd3                                // Drop ack
   } cmd_state_e;

   typedef enum logic [1:0] {
      RST_IDLE    = 2'd0,                            // No request pending
      RST_REQ     = 2'd1,                            // Request high, wait for ack
      RST_RELEASE = 2'd2                             // Wait for ack low
   } rst_state_e;

endpackage

`default_nettype wire

//--- err_lock_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "err_lock_settings.svh"

// Between lock bank, mask registers and control
interface lock_bank_if import err_lock_pkg::*; ();
   src_vec_t               mask;      // Per source hold clear
   src_vec_t               clear_vec; // One cycle clear strobes
   src_sel_t               rd_sel;    // Readback select
   src_vec_t               lock;      // Count nonzero per source
   logic [`ERR_CNT_W-1:0]  rd_cnt;    // Selected counter

   modport regs (
      output mask,
      output clear_vec,
      output rd_sel,
      input  lock,
      input  rd_cnt
   );

   modport bank (
      input  mask,
      input  clear_vec,
      input  rd_sel,
      output lock,
      output rd_cnt
   );

   modport ctrl (
      input  lock                      // Only the any lock reduction
   );
endinterface

// Captured host command towards the register block
interface cfg_if import err_lock_pkg::*; ();
   logic      exec;                    // One cycle per command
   cmd_op_e   op;
   src_sel_t  sel;
   src_vec_t  wdata;
   src_vec_t  rdata;                   // Held until next read

   modport ctrl (output exec, output op, output sel, output wdata);
   modport regs (input exec, input op, input sel, input wdata, output rdata);
endinterface

`default_nettype wire

//--- pulse_cnt.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_cnt #(
   parameter int CNT_WDTH = 4                     // Counter width
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                pulse,             // Level interrupt
   input  logic                clear,             // Mask or clear strobe
   output logic [CNT_WDTH-1:0] cnt
);

   logic pulse_d;                                 // Level seen on last edge
   logic pulse_rise;

   // High now, low last cycle, so a held level counts once
   assign pulse_rise = pulse & ~pulse_d;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pulse_d <= 1'b0;
         cnt     <= '0;
      end else begin
         pulse_d <= pulse;                        // Tracks even while cleared
         if (clear) begin
            cnt <= '0;                            // Clear wins over counting
         end else if (pulse_rise && (cnt != '1)) begin
            cnt <= cnt + CNT_WDTH'(1);            // Stops at all ones
         end
      end
   end

endmodule

`default_nettype wire

//--- err_lock_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "err_lock_settings.svh"

module err_lock_bank import err_lock_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`ERR_OVF_CH-1:0]   ovf_int,        // FIFO overflow levels
   input  logic [`ERR_ALIGN_CH-1:0] align_fail_int, // Align fail levels
   lock_bank_if.bank                bank
);

   src_vec_t              src_int;                  // Sources in index order
   src_vec_t              lock_vec;
   logic [`ERR_CNT_W-1:0] cnt_arr [`ERR_SRC_N];     // All event counts

   // Overflow in 0..7, align fail in 8..11
   assign src_int = {align_fail_int, ovf_int};

   for (genvar i = 0; i < `ERR_SRC_N; i++) begin : g_src
      pulse_cnt #(
         .CNT_WDTH (`ERR_CNT_W)
      ) u_pulse_cnt (
         .clk    (clk),
         .arst_n (arst_n),
         .pulse  (src_int[i]),
         .clear  (bank.mask[i] | bank.clear_vec[i]), // Mask holds, strobe zeroes
         .cnt    (cnt_arr[i])
      );

      assign lock_vec[i] = |cnt_arr[i];             // Any event locks the source
   end

   assign bank.lock = lock_vec;

   // Readback mux, unused indices read zero
   always_comb begin
      bank.rd_cnt = '0;
      if (bank.rd_sel < `ERR_SRC_N) begin
         bank.rd_cnt = cnt_arr[bank.rd_sel];
      end
   end

endmodule

`default_nettype wire

//--- err_mask_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "err_lock_settings.svh"

module err_mask_regs import err_lock_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   lock_bank_if.regs bank,
   cfg_if.regs       cfg
);

   src_vec_t mask_q;                              // Set bit holds counter at zero
   src_vec_t clear_q;                             // Strobes, one cycle wide
   src_vec_t rdata_q;                             // Last read result

   // Mask and clear strobes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mask_q  <= '0;                           // All sources enabled
         clear_q <= '0;
      end else begin
         clear_q <= '0;                           // Self clearing
         if (cfg.exec) begin
            case (cfg.op)
               OP_SET_MASK: begin
                  mask_q <= cfg.wdata;            // Effective on the exec edge
               end
               OP_CLEAR: begin
                  clear_q <= src_vec_t'(1) << cfg.sel; // Out of range sel clears none
               end
               default: begin
               end
            endcase
         end
      end
   end

   // Read results sampled on the exec edge
   always_ff @(posedge clk) begin
      if (cfg.exec) begin
         case (cfg.op)
            OP_READ_CNT: begin
               rdata_q <= src_vec_t'(bank.rd_cnt); // Zero extended
            end
            OP_READ_LOCK: begin
               rdata_q <= bank.lock;
            end
            default: begin
               rdata_q <= rdata_q;                // Writes keep old result
            end
         endcase
      end
   end

   assign bank.mask      = mask_q;
   assign bank.clear_vec = clear_q;
   assign bank.rd_sel    = cfg.sel;               // Captured select, stable during exec
   assign cfg.rdata      = rdata_q;

endmodule

`default_nettype wire

//--- err_lock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "err_lock_settings.svh"

module err_lock_ctrl import err_lock_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      cmd_req,                     // Host request, four phase
   input  cmd_op_e   cmd_op,
   input  src_sel_t  cmd_sel,
   input  src_vec_t  cmd_wdata,
   output logic      cmd_ack,
   output logic      app_async_rst_req,           // To reset controller
   input  logic      app_rst_ack,
   lock_bank_if.ctrl bank,
   cfg_if.ctrl       cfg
);

   cmd_state_e cmd_state;
   rst_state_e rst_state;
   logic       exec_q;                            // One cycle command strobe
   logic       cmd_take;                          // New request accepted
   logic       any_lock;
   cmd_op_e    op_q;
   src_sel_t   sel_q;
   src_vec_t   wdata_q;

   assign cmd_take = (cmd_state == CMD_IDLE) & cmd_req;
   assign any_lock = |bank.lock;

   // Command FSM
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd_state <= CMD_IDLE;
         exec_q    <= 1'b0;
         cmd_ack   <= 1'b0;
      end else begin
         exec_q <= 1'b0;
         case (cmd_state)
            CMD_IDLE: begin
               if (cmd_req) begin
                  exec_q    <= 1'b1;              // Registers act on next edge
                  cmd_state <= CMD_EXEC;
               end
            end
            CMD_EXEC: begin
               cmd_state <= CMD_ACK;              // Result settles here
            end
            CMD_ACK: begin
               if (!cmd_ack) begin
                  cmd_ack <= 1'b1;                // Two edges after req seen
               end else if (!cmd_req) begin
                  cmd_state <= CMD_DONE;          // Stalls here while req held
               end
            end
            CMD_DONE: begin
               cmd_ack   <= 1'b0;
               cmd_state <= CMD_IDLE;
            end
            default: begin
               cmd_state <= CMD_IDLE;
            end
         endcase
      end
   end

   // Command fields, held stable for the whole exchange
   always_ff @(posedge clk) begin
      if (cmd_take) begin
         op_q    <= cmd_op;
         sel_q   <= cmd_sel;
         wdata_q <= cmd_wdata;
      end
   end

   // Reset request FSM
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_state         <= RST_IDLE;
         app_async_rst_req <= 1'b0;
      end else begin
         case (rst_state)
            RST_IDLE: begin
               if (any_lock) begin
                  app_async_rst_req <= 1'b1;
                  rst_state         <= RST_REQ;
               end
            end
            RST_REQ: begin
               if (app_rst_ack) begin
                  app_async_rst_req <= 1'b0;      // Locks stay, only host clears
                  rst_state         <= RST_RELEASE;
               end
            end
            RST_RELEASE: begin
               if (!app_rst_ack) begin
                  rst_state <= RST_IDLE;          // Lock still set means new request
               end
            end
            default: begin
               rst_state <= RST_IDLE;
            end
         endcase
      end
   end

   assign cfg.exec  = exec_q;
   assign cfg.op    = op_q;
   assign cfg.sel   = sel_q;
   assign cfg.wdata = wdata_q;

endmodule

`default_nettype wire

//--- int_reg_lock.sv
`timescale 1ns/1ps
`default_nettype none

`include "err_lock_settings.svh"

module int_reg_lock import err_lock_pkg::*; (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`ERR_OVF_CH-1:0]   ovf_int,           // FIFO overflow levels
   input  logic [`ERR_ALIGN_CH-1:0] align_fail_int,    // Align fail levels
   input  logic                     cmd_req,           // Host command port
   input  cmd_op_e                  cmd_op,
   input  src_sel_t                 cmd_sel,
   input  src_vec_t                 cmd_wdata,
   output logic                     cmd_ack,
   output src_vec_t                 cmd_rdata,         // Valid while ack high
   output logic                     app_async_rst_req, // Reset controller port
   input  logic                     app_rst_ack
);

   lock_bank_if bank_bus ();                           // Counters and registers
   cfg_if       cfg_bus ();                            // Captured command

   err_lock_bank u_err_lock_bank (
      .clk            (clk),
      .arst_n         (arst_n),
      .ovf_int        (ovf_int),
      .align_fail_int (align_fail_int),
      .bank           (bank_bus.bank)
   );

   err_mask_regs u_err_mask_regs (
      .clk    (clk),
      .arst_n (arst_n),
      .bank   (bank_bus.regs),
      .cfg    (cfg_bus.regs)
   );

   err_lock_ctrl u_err_lock_ctrl (
      .clk               (clk),
      .arst_n            (arst_n),
      .cmd_req           (cmd_req),
      .cmd_op            (cmd_op),
      .cmd_sel           (cmd_sel),
      .cmd_wdata         (cmd_wdata),
      .cmd_ack           (cmd_ack),
      .app_async_rst_req (app_async_rst_req),
      .app_rst_ack       (app_rst_ack),
      .bank              (bank_bus.ctrl),
      .cfg               (cfg_bus.ctrl)
   );

   assign cmd_rdata = cfg_bus.rdata;                   // Straight from result register

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS  = 100,                // Clock period
   parameter int RST_CYCLES = 10                  // Edges with reset held
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   initial begin
      arst_n = 1'b0;                              // Asserted from time zero
      repeat (RST_CYCLES) @(posedge clk);
      #5 arst_n = 1'b1;                           // Off the edge like other inputs
   end

endmodule

`default_nettype wire

//--- int_reg_lock_properties.sv
`timescale 1ns/1ps
`default_nettype none

module int_reg_lock_properties (
   input logic clk,
   input logic arst_n,
   input logic cmd_req,
   input logic cmd_ack,
   input logic app_async_rst_req,
   input logic app_rst_ack
);

   // Ack only answers a pending request
   ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(cmd_ack) |-> $past(cmd_req))
      else $error("cmd_ack rose without cmd_req");

   // Request held until the controller acks
   req_held_to_ack: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(app_async_rst_req) |-> $past(app_rst_ack))
      else $error("app_async_rst_req fell before app_rst_ack");

   // New request only after ack is back low
   no_req_during_ack: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(app_async_rst_req) |-> !$past(app_rst_ack))
      else $error("app_async_rst_req rose while app_rst_ack high");

   outputs_low_in_reset: assert property (@(posedge clk)
      !arst_n |-> (!cmd_ack && !app_async_rst_req))
      else $error("handshake output high during reset");

endmodule

bind int_reg_lock int_reg_lock_properties props_inst (
   .clk               (clk),
   .arst_n            (arst_n),
   .cmd_req           (cmd_req),
   .cmd_ack           (cmd_ack),
   .app_async_rst_req (app_async_rst_req),
   .app_rst_ack       (app_rst_ack)
);

`default_nettype wire

//--- tb_int_reg_lock.sv
`timescale 1ns/1ps
`default_nettype none

`include "err_lock_settings.svh"

module tb_int_reg_lock import err_lock_pkg::*; ();

   localparam int TIMEOUT_CYC = 200;              // Bound of every wait loop

   typedef logic [`ERR_CNT_W-1:0] cnt_t;
   typedef struct packed {
      src_sel_t   src;                            // Source under test
      logic [7:0] pulses;
      src_vec_t   mask;                           // Written before the pulses
      cnt_t       exp_cnt;
      src_vec_t   exp_lock;                       // Whole vector after the row
   } stim_row_t;

   logic      clk;
   logic      arst_n;
   src_vec_t  src_drive;                          // Interrupt levels in source order
   logic      cmd_req;
   cmd_op_e   cmd_op;
   src_sel_t  cmd_sel;
   src_vec_t  cmd_wdata;
   logic      cmd_ack;
   src_vec_t  cmd_rdata;
   logic      app_async_rst_req;
   logic      app_rst_ack;
   stim_row_t stim_tbl [8];
   integer    seed;
   int        ack_delay;
   int        rst_exchanges;                      // Completed reset handshakes
   int        waited;
   int        base;
   src_vec_t  lock_exp;
   src_vec_t  rd_val;

   tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(10)) clkgen_inst (.clk(clk), .arst_n(arst_n));

   int_reg_lock int_reg_lock_inst (
      .clk               (clk),
      .arst_n            (arst_n),
      .ovf_int           (src_drive[`ERR_OVF_CH-1:0]),
      .align_fail_int    (src_drive[`ERR_SRC_N-1:`ERR_OVF_CH]),
      .cmd_req           (cmd_req),
      .cmd_op            (cmd_op),
      .cmd_sel           (cmd_sel),
      .cmd_wdata         (cmd_wdata),
      .cmd_ack           (cmd_ack),
      .cmd_rdata         (cmd_rdata),
      .app_async_rst_req (app_async_rst_req),
      .app_rst_ack       (app_rst_ack)
   );

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #5;                                         // Clear of the edge
   endtask

   task automatic check_cnt(input cnt_t got, input cnt_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_vec(input src_vec_t got, input src_vec_t exp, input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // Host side of the four phase command exchange
   task automatic run_cmd(input cmd_op_e op, input src_sel_t sel, input src_vec_t wdata,
                          output src_vec_t rdata);
      int cnt;
      cmd_op    = op;
      cmd_sel   = sel;
      cmd_wdata = wdata;
      cmd_req   = 1'b1;
      cnt       = 0;
      while (!cmd_ack && cnt < TIMEOUT_CYC) begin
         next_cycle();
         cnt++;
      end
      if (!cmd_ack) begin
         $display("Timeout: the DUT never raised cmd_ack");
         abort_run();
      end
      rdata   = cmd_rdata;                        // Valid while ack high
      cmd_req = 1'b0;
      cnt     = 0;
      while (cmd_ack && cnt < TIMEOUT_CYC) begin
         next_cycle();
         cnt++;
      end
      if (cmd_ack) begin
         $display("Timeout: the DUT never dropped cmd_ack");
         abort_run();
      end
   endtask

   task automatic pulse_source(input src_sel_t src, input int n);
      for (int p = 0; p < n; p++) begin
         src_drive[src] = 1'b1;
         next_cycle();
         src_drive[src] = 1'b0;
         next_cycle();
      end
   endtask

   task automatic quiet_check(input int n);
      repeat (n) begin
         next_cycle();
         if (app_async_rst_req) begin
            $display("Error: reset request raised although no source is locked");
            abort_run();
         end
      end
   endtask

   // Reset controller, answers after a random number of cycles
   initial begin
      seed          = 32'h63db1e46;
      app_rst_ack   = 1'b0;
      rst_exchanges = 0;
      ack_delay     = 1 + ($random(seed) & 7);
      forever begin
         next_cycle();
         if (app_async_rst_req && !app_rst_ack) begin
            if (ack_delay == 0) begin
               app_rst_ack = 1'b1;
               ack_delay   = 1 + ($random(seed) & 7);
            end else begin
               ack_delay--;
            end
         end else if (!app_async_rst_req && app_rst_ack) begin
            if (ack_delay == 0) begin
               app_rst_ack = 1'b0;                // Exchange complete
               rst_exchanges++;
               ack_delay   = 1 + ($random(seed) & 7);
            end else begin
               ack_delay--;
            end
         end
      end
   end

   initial begin
      src_drive = '0;
      cmd_req   = 1'b0;
      cmd_op    = OP_READ_LOCK;
      cmd_sel   = '0;
      cmd_wdata = '0;
      // src, pulses, mask before, count, lock vector
      stim_tbl[0] = '{4'd0,  8'd3,  12'h000, 4'd3,  12'h001};
      stim_tbl[1] = '{4'd5,  8'd15, 12'h000, 4'd15, 12'h021};
      stim_tbl[2] = '{4'd8,  8'd20, 12'h000, 4'd15, 12'h121}; // Saturates
      stim_tbl[3] = '{4'd11, 8'd1,  12'h000, 4'd1,  12'h921};
      stim_tbl[4] = '{4'd3,  8'd4,  12'h008, 4'd0,  12'h921}; // Masked overflow
      stim_tbl[5] = '{4'd9,  8'd2,  12'h200, 4'd0,  12'h921}; // Masked align fail
      stim_tbl[6] = '{4'd5,  8'd0,  12'h020, 4'd0,  12'h901}; // Mask wipes count
      stim_tbl[7] = '{4'd7,  8'd6,  12'h000, 4'd6,  12'h981};
      waited = 0;
      while (!arst_n && waited < TIMEOUT_CYC) begin
         @(posedge clk);
         waited++;
      end
      if (!arst_n) begin
         $display("Timeout: reset was never released");
         abort_run();
      end
      next_cycle();
      run_cmd(OP_READ_LOCK, '0, '0, rd_val);
      check_vec(rd_val, '0, "lock vector after reset");
      quiet_check(10);
      for (int i = 0; i < 8; i++) begin
         run_cmd(OP_SET_MASK, '0, stim_tbl[i].mask, rd_val);
         pulse_source(stim_tbl[i].src, int'(stim_tbl[i].pulses));
         next_cycle();
         run_cmd(OP_READ_CNT, stim_tbl[i].src, '0, rd_val);
         check_cnt(cnt_t'(rd_val), stim_tbl[i].exp_cnt, $sformatf("row %0d count", i));
         check_vec(rd_val >> `ERR_CNT_W, '0, $sformatf("row %0d count upper bits", i));
         run_cmd(OP_READ_LOCK, '0, '0, rd_val);
         check_vec(rd_val, stim_tbl[i].exp_lock, $sformatf("row %0d lock vector", i));
      end
      base   = rst_exchanges;                     // Locks pending, expect a full exchange
      waited = 0;
      while (rst_exchanges == base && waited < TIMEOUT_CYC) begin
         next_cycle();
         waited++;
      end
      if (rst_exchanges == base) begin
         $display("Timeout: no complete reset request exchange while locked");
         abort_run();
      end
      src_drive[2] = 1'b1;                        // Held level counts once
      repeat (6) next_cycle();
      src_drive[2] = 1'b0;
      next_cycle();
      run_cmd(OP_READ_CNT, 4'd2, '0, rd_val);
      check_cnt(cnt_t'(rd_val), 4'd1, "held level count on source 2");
      lock_exp = stim_tbl[7].exp_lock | 12'h004;
      run_cmd(OP_CLEAR, 4'd7, '0, rd_val);
      lock_exp[7] = 1'b0;
      run_cmd(OP_READ_CNT, 4'd0, '0, rd_val);
      check_cnt(cnt_t'(rd_val), stim_tbl[0].exp_cnt, "source 0 count after clear of 7");
      run_cmd(OP_READ_LOCK, '0, '0, rd_val);
      check_vec(rd_val, lock_exp, "lock vector after clear of source 7");
      for (int s = 0; s < `ERR_SRC_N; s++) begin
         if (lock_exp[s]) begin
            run_cmd(OP_CLEAR, src_sel_t'(s), '0, rd_val);
         end
      end
      run_cmd(OP_READ_LOCK, '0, '0, rd_val);
      check_vec(rd_val, '0, "lock vector after clearing all sources");
      waited = 0;
      while ((app_async_rst_req || app_rst_ack) && waited < TIMEOUT_CYC) begin
         next_cycle();
         waited++;
      end
      if (app_async_rst_req || app_rst_ack) begin
         $display("Timeout: reset request exchange did not finish");
         abort_run();
      end
      quiet_check(20);
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
err_lock_pkg.sv
err_lock_if.sv
pulse_cnt.sv
err_lock_bank.sv
err_mask_regs.sv
err_lock_ctrl.sv
int_reg_lock.sv
tb_clkgen.sv
int_reg_lock_properties.sv
tb_int_reg_lock.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_int_reg_lock -f vlog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
